// ==== cdram_pkg.sv ====
package cdram_pkg;

    // DFI port geometry
    localparam int ROW_W = 15;
    localparam int TIMING_W = 4;
    localparam int PHASES = 4;

    // Slot program layout
    localparam int SETTLE_SLOTS = 5;
    localparam int PROG_SLOTS = 48;
    localparam int INDEX_W = 6;

    typedef enum logic [1:0] {
        op_wait = 2'd0,
        op_act  = 2'd1,
        op_pre  = 2'd2,
        op_stop = 2'd3
    } op_e;

    typedef enum logic {
        st_idle,
        st_issue
    } issue_state_e;

    typedef logic [ROW_W-1:0] row_t;
    typedef logic [TIMING_W-1:0] timing_t;

    // Request payload of 38 bits
    typedef struct packed {
        row_t    row_first;
        row_t    row_second;
        timing_t t_open;
        timing_t t_close;
    } hammer_req_t;

    // Slots issued together in one controller cycle
    typedef op_e [PHASES-1:0] op_window_t;

    // One DFI phase command of 19 bits
    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
        row_t address;
    } dfi_cmd_t;

    // Phase 0 sits in the low bits
    typedef dfi_cmd_t [PHASES-1:0] dfi_phases_t;

endpackage

// ==== seq_ctrl.sv ====
`timescale 1ns/1ns

module seq_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  cdram_pkg::op_window_t         window,
    output logic                          load,
    output logic                          issuing,
    output logic [cdram_pkg::INDEX_W-1:0] slot_base
);

    cdram_pkg::issue_state_e state;
    logic last_window;

    assign req_ready = (state == cdram_pkg::st_idle);
    assign issuing = (state == cdram_pkg::st_issue);

    // Accept only while idle
    assign load = req_valid && req_ready;

    // Stop in phase 3 marks the final issue cycle
    assign last_window = issuing &&
                         (window[cdram_pkg::PHASES-1] == cdram_pkg::op_stop);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cdram_pkg::st_idle;
        end else begin
            case (state)
                cdram_pkg::st_idle: begin
                    if (load) begin
                        state <= cdram_pkg::st_issue;
                    end
                end
                cdram_pkg::st_issue: begin
                    if (last_window) begin
                        state <= cdram_pkg::st_idle;
                    end
                end
                default: begin
                    state <= cdram_pkg::st_idle;
                end
            endcase
        end
    end

    // Window index returns to slot 0 whenever not issuing
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_base <= '0;
        end else if (issuing && !last_window) begin
            slot_base <= slot_base + cdram_pkg::INDEX_W'(cdram_pkg::PHASES);
        end else begin
            slot_base <= '0;
        end
    end

endmodule

// ==== slot_program.sv ====
`timescale 1ns/1ns

module slot_program (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load,
    input  cdram_pkg::timing_t            t_open,
    input  cdram_pkg::timing_t            t_close,
    input  logic [cdram_pkg::INDEX_W-1:0] slot_base,
    output cdram_pkg::op_window_t         window
);

    cdram_pkg::op_e [cdram_pkg::PROG_SLOTS-1:0] prog_d;
    cdram_pkg::op_e [cdram_pkg::PROG_SLOTS-1:0] prog_q;

    logic [cdram_pkg::INDEX_W-1:0] act1_slot;
    logic [cdram_pkg::INDEX_W-1:0] pre2_slot;
    logic [cdram_pkg::INDEX_W-1:0] act2_slot;
    logic [cdram_pkg::INDEX_W-1:0] pre3_slot;
    logic [cdram_pkg::INDEX_W-1:0] stop_slot;

    // Command positions for this request
    assign act1_slot = cdram_pkg::INDEX_W'(cdram_pkg::SETTLE_SLOTS + 1);
    assign pre2_slot = act1_slot + cdram_pkg::INDEX_W'(t_open) + 1'b1;
    assign act2_slot = pre2_slot + cdram_pkg::INDEX_W'(t_close) + 1'b1;
    assign pre3_slot = act2_slot + cdram_pkg::INDEX_W'(cdram_pkg::SETTLE_SLOTS + 1);
    assign stop_slot = pre3_slot + 1'b1;

    always_comb begin
        for (int i = 0; i < cdram_pkg::PROG_SLOTS; i++) begin
            if (cdram_pkg::INDEX_W'(i) >= stop_slot) begin
                prog_d[i] = cdram_pkg::op_stop;
            end else if (cdram_pkg::INDEX_W'(i) == '0 ||
                         cdram_pkg::INDEX_W'(i) == pre2_slot ||
                         cdram_pkg::INDEX_W'(i) == pre3_slot) begin
                prog_d[i] = cdram_pkg::op_pre;
            end else if (cdram_pkg::INDEX_W'(i) == act1_slot ||
                         cdram_pkg::INDEX_W'(i) == act2_slot) begin
                prog_d[i] = cdram_pkg::op_act;
            end else begin
                prog_d[i] = cdram_pkg::op_wait;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cdram_pkg::PROG_SLOTS; i++) begin
                prog_q[i] <= cdram_pkg::op_stop;
            end
        end else if (load) begin
            prog_q <= prog_d;
        end
    end

    // Latest window starts at slot 44, so the select stays in range
    assign window = prog_q[slot_base +: cdram_pkg::PHASES];

endmodule

// ==== command_encoder.sv ====
`timescale 1ns/1ns

module command_encoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  cdram_pkg::row_t        row_first,
    input  cdram_pkg::row_t        row_second,
    input  logic                   issuing,
    input  cdram_pkg::op_window_t  window,
    output cdram_pkg::dfi_phases_t dfi
);

    cdram_pkg::row_t row_first_q;
    cdram_pkg::row_t row_second_q;

    // Activates already issued in earlier cycles
    logic [2:0] act_issued;

    // Activates in the current window ahead of each phase
    logic [2:0] act_before [0:cdram_pkg::PHASES];

    cdram_pkg::row_t row_sel [cdram_pkg::PHASES];

    function automatic cdram_pkg::dfi_cmd_t encode(
        input cdram_pkg::op_e  op,
        input cdram_pkg::row_t row
    );
        cdram_pkg::dfi_cmd_t cmd;
        cmd.cs_n = 1'b1;
        cmd.ras_n = 1'b1;
        cmd.cas_n = 1'b1;
        cmd.we_n = 1'b1;
        cmd.address = '0;
        case (op)
            cdram_pkg::op_act: begin
                cmd.cs_n = 1'b0;
                cmd.ras_n = 1'b0;
                cmd.address = row;
            end
            cdram_pkg::op_pre: begin
                cmd.cs_n = 1'b0;
                cmd.ras_n = 1'b0;
                cmd.we_n = 1'b0;
            end
            // Wait and stop go out as NOP
            default: ;
        endcase
        return cmd;
    endfunction

    always_ff @(posedge clk) begin
        if (load) begin
            row_first_q <= row_first;
            row_second_q <= row_second;
        end
    end

    always_comb begin
        act_before[0] = 3'd0;
        for (int p = 0; p < cdram_pkg::PHASES; p++) begin
            act_before[p+1] = act_before[p] +
                              ((window[p] == cdram_pkg::op_act) ? 3'd1 : 3'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            act_issued <= 3'd0;
        end else if (load) begin
            act_issued <= 3'd0;
        end else if (issuing) begin
            act_issued <= act_issued + act_before[cdram_pkg::PHASES];
        end
    end

    // First activate of the sequence takes row_first, any later one row_second
    always_comb begin
        for (int p = 0; p < cdram_pkg::PHASES; p++) begin
            if (act_issued + act_before[p] == 3'd0) begin
                row_sel[p] = row_first_q;
            end else begin
                row_sel[p] = row_second_q;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < cdram_pkg::PHASES; p++) begin
            if (issuing) begin
                dfi[p] = encode(window[p], row_sel[p]);
            end else begin
                dfi[p] = encode(cdram_pkg::op_wait, '0);
            end
        end
    end

endmodule

// ==== compute_dram_top.sv ====
`timescale 1ns/1ns

module compute_dram_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  cdram_pkg::hammer_req_t req,
    output cdram_pkg::dfi_phases_t dfi
);

    logic                          load;
    logic                          issuing;
    logic [cdram_pkg::INDEX_W-1:0] slot_base;
    cdram_pkg::op_window_t         window;

    seq_ctrl u_seq_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .window    (window),
        .load      (load),
        .issuing   (issuing),
        .slot_base (slot_base)
    );

    // Timings shape the program
    slot_program u_slot_program (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .t_open    (req.t_open),
        .t_close   (req.t_close),
        .slot_base (slot_base),
        .window    (window)
    );

    // Rows only matter to the encoder
    command_encoder u_command_encoder (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .row_first  (req.row_first),
        .row_second (req.row_second),
        .issuing    (issuing),
        .window     (window),
        .dfi        (dfi)
    );

endmodule

// ==== tb_compute_dram.sv ====
`timescale 1ns/1ns

module tb_compute_dram;

    localparam int EXP_SLOTS = 64;
    localparam int READY_LIMIT = 20;
    localparam int BUSY_LIMIT = 15;

    // {cs_n, ras_n, cas_n, we_n, address}
    localparam logic [18:0] NOP_CMD = {4'b1111, 15'd0};
    localparam logic [18:0] PRE_CMD = {4'b0010, 15'd0};
    localparam logic [3:0] ACT_CTL = 4'b0011;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    cdram_pkg::hammer_req_t req;
    cdram_pkg::dfi_phases_t dfi;

    logic [18:0] exp_cmd [0:EXP_SLOTS-1];
    int exp_cycles;
    int errors;
    logic [31:0] lcg_state;

    compute_dram_top dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .dfi       (dfi)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic cdram_pkg::hammer_req_t make_req(
        input logic [14:0] row_a,
        input logic [14:0] row_b,
        input logic [3:0]  t_open,
        input logic [3:0]  t_close
    );
        cdram_pkg::hammer_req_t r;
        r.row_first = row_a;
        r.row_second = row_b;
        r.t_open = t_open;
        r.t_close = t_close;
        return r;
    endfunction

    // Expected phase command for every slot of one request
    function automatic void build_expected(input cdram_pkg::hammer_req_t r);
        int o;
        int c;
        o = r.t_open;
        c = r.t_close;
        for (int s = 0; s < EXP_SLOTS; s++) begin
            exp_cmd[s] = NOP_CMD;
        end
        exp_cmd[0] = PRE_CMD;
        exp_cmd[6] = {ACT_CTL, r.row_first};
        exp_cmd[7 + o] = PRE_CMD;
        exp_cmd[8 + o + c] = {ACT_CTL, r.row_second};
        exp_cmd[14 + o + c] = PRE_CMD;
        exp_cycles = 1;
        while (4 * exp_cycles - 1 < 15 + o + c) begin
            exp_cycles++;
        end
    endfunction

    task automatic value_fail(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        errors++;
        $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("Timeout: %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic check_idle(input string name);
        for (int p = 0; p < 4; p++) begin
            assert (dfi[p] == NOP_CMD)
                else value_fail($sformatf("%s idle phase %0d", name, p), NOP_CMD, dfi[p]);
        end
    endtask

    task automatic check_window(input int j, input string name);
        int s;
        for (int p = 0; p < 4; p++) begin
            s = 4 * j + p;
            assert (dfi[p] == exp_cmd[s])
                else value_fail($sformatf("%s slot %0d", name, s), exp_cmd[s], dfi[p]);
        end
    endtask

    // Send one request, hold a decoy while busy, check every issue cycle
    task automatic run_request(
        input cdram_pkg::hammer_req_t r,
        input cdram_pkg::hammer_req_t decoy,
        input string                  name
    );
        int waited;
        int cycles;
        bit done;
        build_expected(r);
        waited = 0;
        while (!req_ready) begin
            waited++;
            if (waited > READY_LIMIT) begin
                timeout_fail({name, ": req_ready never went high before the request"});
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req = decoy;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            // Drop valid in the last expected issue cycle so the decoy is never taken
            if (cycles == exp_cycles - 1) begin
                req_valid = 1'b0;
            end
            @(negedge clk);
            if (req_ready) begin
                done = 1'b1;
            end else begin
                check_window(cycles, name);
                cycles++;
                if (cycles > BUSY_LIMIT) begin
                    timeout_fail({name, ": sequencer stayed busy too long"});
                end
                @(posedge clk);
                #1;
            end
        end
        assert (cycles == exp_cycles)
            else value_fail({name, " issue cycles"}, exp_cycles, cycles);
        check_idle(name);
    endtask

    initial begin
        cdram_pkg::hammer_req_t r;
        cdram_pkg::hammer_req_t d;
        logic [31:0] rnd;
        errors = 0;
        lcg_state = 32'd72;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) begin
            @(negedge clk);
            assert (req_ready == 1'b1)
                else value_fail("reset req_ready", 1, req_ready);
            check_idle("reset");
        end

        d = make_req(15'h7fff, 15'h5555, 4'd0, 4'd15);
        run_request(make_req(15'h1234, 15'h4321, 4'd2, 4'd2), d, "directed 2_2");
        run_request(make_req(15'h0abc, 15'h6def, 4'd0, 4'd0), d, "directed 0_0");
        run_request(make_req(15'h2001, 15'h1002, 4'd1, 4'd0), d, "directed 1_0");
        run_request(make_req(15'h3333, 15'h4444, 4'd15, 4'd15), d, "directed 15_15");

        for (int i = 0; i < 30; i++) begin
            rnd = lcg_next();
            r.row_first = rnd[30:16];
            rnd = lcg_next();
            r.row_second = rnd[30:16];
            rnd = lcg_next();
            r.t_open = rnd[31:28];
            rnd = lcg_next();
            r.t_close = rnd[31:28];
            // Longest program somewhere in the middle of the run
            if (i == 12) begin
                r.t_open = 4'd15;
                r.t_close = 4'd15;
            end
            rnd = lcg_next();
            d.row_first = rnd[30:16];
            d.row_second = ~rnd[30:16];
            d.t_open = rnd[27:24];
            d.t_close = rnd[23:20];
            run_request(r, d, $sformatf("random %0d", i));
        end

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
cdram_pkg.sv
seq_ctrl.sv
slot_program.sv
command_encoder.sv
compute_dram_top.sv
tb_compute_dram.sv
